//--- layer_exec.f
source/layer_exec_pkg.sv
source/acc_stream_if.sv
source/layer_sequencer.sv
source/gap_accumulator.sv
source/requantize_lanes.sv
source/layer_exec.sv
testbench/tb_feature_mem.sv
testbench/tb_layer_exec.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the layer_exec testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_layer_exec \
  -f layer_exec.f \
  -o sim_layer_exec

# The simulator exits nonzero on a failure, the log decides the result
./obj_dir/sim_layer_exec > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- source/acc_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// Finished block sums, accumulator to requantizer
interface acc_stream_if #(
  parameter int ADDR_W = 16
);
  import layer_exec_pkg::*;

  logic              valid;
  acc_vec_t          sums;
  logic [ADDR_W-1:0] block_idx;
  logic              last;

  // No ready signal, the sink takes every pulse
  modport source (output valid, output sums, output block_idx, output last);
  modport sink   (input valid, input sums, input block_idx, input last);

endinterface

`default_nettype wire

//--- source/gap_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module gap_accumulator #(
  parameter int ADDR_W = 16
) (
  input  wire                          CLK,
  input  wire                          RESETn,
  input  wire                          ap_start,
  input  wire layer_exec_pkg::chan_cnt_t  cin,
  input  wire layer_exec_pkg::dim_t       img_w,
  input  wire layer_exec_pkg::dim_t       img_h,
  output logic                         feat_rd_en,
  output logic [ADDR_W-1:0]            feat_rd_addr,
  input  wire layer_exec_pkg::feat_word_t feat_rd_data,
  input  wire                          feat_rd_valid,
  acc_stream_if.source                 acc
);
  import layer_exec_pkg::*;

  // Up to 128 blocks for an 11-bit channel count
  localparam int BLK_W = 8;
  localparam int PIX_W = 2 * $bits(dim_t);

  typedef enum logic [1:0] {
    G_IDLE,
    G_ISSUE,
    G_WAIT
  } gap_state_t;

  gap_state_t        state;
  logic [BLK_W-1:0]  n_blocks;
  logic [BLK_W-1:0]  blk;
  logic [PIX_W-1:0]  n_pix;
  logic [PIX_W-1:0]  pix;
  logic [ADDR_W-1:0] pix_base;
  logic              last_pix;
  logic              last_blk;
  logic              beat;
  acc_vec_t          sums;
  acc_vec_t          sums_nxt;

  assign last_pix = (pix == n_pix - 1'b1);
  assign last_blk = (blk == n_blocks - 1'b1);
  assign beat     = (state == G_WAIT) && feat_rd_valid;

  // ========================================
  // Read requests
  // ========================================

  // Word for pixel p, block b sits at p*blocks + b
  assign feat_rd_en   = (state == G_ISSUE);
  assign feat_rd_addr = pix_base + ADDR_W'(blk);

  always_ff @(posedge CLK or negedge RESETn) begin
    if (!RESETn) begin
      state     <= G_IDLE;
      n_blocks  <= '0;
      n_pix     <= '0;
      blk       <= '0;
      pix       <= '0;
      pix_base  <= '0;
      acc.valid <= 1'b0;
    end else begin
      acc.valid <= 1'b0;
      case (state)
        G_IDLE: begin
          if (ap_start) begin
            n_blocks <= BLK_W'((12'(cin) + 12'd15) >> 4);
            n_pix    <= img_w * img_h;
            blk      <= '0;
            pix      <= '0;
            pix_base <= '0;
            state    <= G_ISSUE;
          end
        end
        G_ISSUE: begin
          // One outstanding read at a time
          state <= G_WAIT;
        end
        G_WAIT: begin
          if (feat_rd_valid) begin
            if (last_pix) begin
              acc.valid <= 1'b1;
              pix       <= '0;
              pix_base  <= '0;
              if (last_blk) begin
                state <= G_IDLE;
              end else begin
                blk   <= blk + 1'b1;
                state <= G_ISSUE;
              end
            end else begin
              pix      <= pix + 1'b1;
              pix_base <= pix_base + ADDR_W'(n_blocks);
              state    <= G_ISSUE;
            end
          end
        end
        default: begin
          state <= G_IDLE;
        end
      endcase
    end
  end

  // ========================================
  // Lane sums
  // ========================================
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      sums_nxt[l*ACC_W +: ACC_W] = sums[l*ACC_W +: ACC_W]
                                 + ACC_W'($signed(feat_rd_data[l*DATA_W +: DATA_W]));
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == G_IDLE) && ap_start) begin
      sums <= '0;
    end else if (beat) begin
      if (last_pix) begin
        // Hand the block over and start the next one from zero
        acc.sums      <= sums_nxt;
        acc.block_idx <= ADDR_W'(blk);
        acc.last      <= last_blk;
        sums          <= '0;
      end else begin
        sums <= sums_nxt;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/layer_exec.sv
`timescale 1ns/100ps
`default_nettype none

module layer_exec #(
  parameter int ADDR_W = 16
) (
  input  wire                             CLK,
  input  wire                             RESETn,
  input  wire                             start,
  output wire                             done,
  // Layer configuration
  input  wire layer_exec_pkg::layer_type_t   layer_type,
  input  wire layer_exec_pkg::chan_cnt_t     cin,
  input  wire layer_exec_pkg::dim_t          img_w,
  input  wire layer_exec_pkg::dim_t          img_h,
  input  wire layer_exec_pkg::quant_mult_t   quant_M,
  input  wire layer_exec_pkg::quant_shift_t  quant_s,
  input  wire layer_exec_pkg::quant_zp_t     quant_zp,
  // Feature buffer read side
  output wire                             feat_rd_en,
  output wire [ADDR_W-1:0]                feat_rd_addr,
  input  wire layer_exec_pkg::feat_word_t    feat_rd_data,
  input  wire                             feat_rd_valid,
  // Feature buffer write side
  output wire                             feat_wr_en,
  output wire [ADDR_W-1:0]                feat_wr_addr,
  output wire layer_exec_pkg::feat_word_t    feat_wr_data
);

  wire ap_start;
  wire layer_done_wr;

  acc_stream_if #(
    .ADDR_W (ADDR_W)
  ) i_acc_stream ();

  // ========================================
  // Control
  // ========================================
  layer_sequencer i_sequencer (
    .CLK           (CLK),
    .RESETn        (RESETn),
    .start         (start),
    .layer_type    (layer_type),
    .ap_start      (ap_start),
    .layer_done_wr (layer_done_wr),
    .done          (done)
  );

  // ========================================
  // Global average pooling path
  // ========================================
  gap_accumulator #(
    .ADDR_W (ADDR_W)
  ) i_gap_accumulator (
    .CLK           (CLK),
    .RESETn        (RESETn),
    .ap_start      (ap_start),
    .cin           (cin),
    .img_w         (img_w),
    .img_h         (img_h),
    .feat_rd_en    (feat_rd_en),
    .feat_rd_addr  (feat_rd_addr),
    .feat_rd_data  (feat_rd_data),
    .feat_rd_valid (feat_rd_valid),
    .acc           (i_acc_stream.source)
  );

  // Pool area divide is folded into quant_M
  requantize_lanes #(
    .ADDR_W (ADDR_W)
  ) i_requantize_lanes (
    .CLK           (CLK),
    .RESETn        (RESETn),
    .acc           (i_acc_stream.sink),
    .quant_M       (quant_M),
    .quant_s       (quant_s),
    .quant_zp      (quant_zp),
    .feat_wr_en    (feat_wr_en),
    .feat_wr_addr  (feat_wr_addr),
    .feat_wr_data  (feat_wr_data),
    .layer_done_wr (layer_done_wr)
  );

endmodule

`default_nettype wire

//--- source/layer_exec_pkg.sv
`default_nettype none

package layer_exec_pkg;

  // ========================================
  // Datapath geometry
  // ========================================

  // int8 channels packed in one feature word
  localparam int LANES  = 16;
  localparam int DATA_W = 8;
  localparam int ACC_W  = 32;

  // One feature buffer word, lane 0 in the low byte
  typedef logic [LANES*DATA_W-1:0] feat_word_t;

  // Lane sums, lane 0 in the low 32 bits
  typedef logic [LANES*ACC_W-1:0] acc_vec_t;

  // ========================================
  // Quantization and layer shape
  // ========================================

  typedef logic signed [15:0] quant_mult_t;
  typedef logic        [5:0]  quant_shift_t;
  typedef logic signed [7:0]  quant_zp_t;

  typedef logic [10:0] chan_cnt_t;
  typedef logic [7:0]  dim_t;

  // Layer type codes as seen on the command port
  typedef enum logic [2:0] {
    LAYER_CONV = 3'd0,
    LAYER_DW   = 3'd1,
    LAYER_PW   = 3'd2,
    LAYER_AP   = 3'd3,
    LAYER_FC   = 3'd4
  } layer_type_t;

endpackage

`default_nettype wire

//--- source/layer_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module layer_sequencer (
  input  wire                         CLK,
  input  wire                         RESETn,
  input  wire                         start,
  input  wire layer_exec_pkg::layer_type_t layer_type,
  output logic                        ap_start,
  input  wire                         layer_done_wr,
  output logic                        done
);
  import layer_exec_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN_AP,
    S_BYPASS
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       ap_go;
  logic       done_nxt;

  // ========================================
  // Next state
  // ========================================
  always_comb begin
    state_nxt = state;
    ap_go     = 1'b0;
    done_nxt  = 1'b0;
    case (state)
      S_IDLE: begin
        // Start is only looked at here
        if (start) begin
          if (layer_type == LAYER_AP) begin
            state_nxt = S_RUN_AP;
            ap_go     = 1'b1;
          end else begin
            // Compute paths for these types are not present
            state_nxt = S_BYPASS;
            done_nxt  = 1'b1;
          end
        end
      end
      S_RUN_AP: begin
        if (layer_done_wr) begin
          state_nxt = S_IDLE;
          done_nxt  = 1'b1;
        end
      end
      S_BYPASS: begin
        state_nxt = S_IDLE;
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  // Done and ap_start come out one cycle after their cause
  always_ff @(posedge CLK or negedge RESETn) begin
    if (!RESETn) begin
      state    <= S_IDLE;
      ap_start <= 1'b0;
      done     <= 1'b0;
    end else begin
      state    <= state_nxt;
      ap_start <= ap_go;
      done     <= done_nxt;
    end
  end

endmodule

`default_nettype wire

//--- source/requantize_lanes.sv
`timescale 1ns/100ps
`default_nettype none

module requantize_lanes #(
  parameter int ADDR_W = 16
) (
  input  wire                            CLK,
  input  wire                            RESETn,
  acc_stream_if.sink                     acc,
  input  wire layer_exec_pkg::quant_mult_t  quant_M,
  input  wire layer_exec_pkg::quant_shift_t quant_s,
  input  wire layer_exec_pkg::quant_zp_t    quant_zp,
  output logic                           feat_wr_en,
  output logic [ADDR_W-1:0]              feat_wr_addr,
  output layer_exec_pkg::feat_word_t     feat_wr_data,
  output logic                           layer_done_wr
);
  import layer_exec_pkg::*;

  localparam int PROD_W = ACC_W + $bits(quant_mult_t);
  // Room for a rounding term up to 2**62
  localparam int EXT_W  = 64;

  logic signed [PROD_W-1:0] prod [LANES];
  logic                     v1;
  logic                     last1;
  logic [ADDR_W-1:0]        idx1;

  // Round, shift, zero point, clamp to int8
  function automatic logic [DATA_W-1:0] requant(input logic signed [PROD_W-1:0] p,
                                                input quant_shift_t s,
                                                input quant_zp_t zp);
    logic signed [EXT_W-1:0] x;
    logic signed [EXT_W-1:0] rnd;
    x   = EXT_W'(p);
    rnd = (s != '0) ? (64'sd1 <<< (s - 1'b1)) : 64'sd0;
    x   = (x + rnd) >>> s;
    x   = x + EXT_W'(zp);
    if (x > 127) begin
      return 8'h7f;
    end else if (x < -128) begin
      return 8'h80;
    end
    return x[DATA_W-1:0];
  endfunction

  // ========================================
  // Valid pipeline
  // ========================================
  always_ff @(posedge CLK or negedge RESETn) begin
    if (!RESETn) begin
      v1            <= 1'b0;
      feat_wr_en    <= 1'b0;
      layer_done_wr <= 1'b0;
    end else begin
      v1            <= acc.valid;
      feat_wr_en    <= v1;
      layer_done_wr <= v1 && last1;
    end
  end

  // ========================================
  // Stage 1 multiply, stage 2 scale
  // ========================================
  always_ff @(posedge CLK) begin
    if (acc.valid) begin
      for (int l = 0; l < LANES; l++) begin
        prod[l] <= $signed(acc.sums[l*ACC_W +: ACC_W]) * quant_M;
      end
      idx1  <= acc.block_idx;
      last1 <= acc.last;
    end
    if (v1) begin
      for (int l = 0; l < LANES; l++) begin
        feat_wr_data[l*DATA_W +: DATA_W] <= requant(prod[l], quant_s, quant_zp);
      end
      // Output word for block b goes to address b
      feat_wr_addr <= idx1;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_feature_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_feature_mem #(
  parameter int ADDR_W     = 16,
  parameter int RD_LATENCY = 3,
  parameter int DEPTH      = 256
) (
  input  wire                        CLK,
  input  wire                        RESETn,
  input  wire                        feat_rd_en,
  input  wire [ADDR_W-1:0]           feat_rd_addr,
  output layer_exec_pkg::feat_word_t feat_rd_data,
  output logic                       feat_rd_valid,
  input  wire                        feat_wr_en,
  input  wire [ADDR_W-1:0]           feat_wr_addr,
  input  wire layer_exec_pkg::feat_word_t feat_wr_data
);
  import layer_exec_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  // Contents are loaded by the test itself
  feat_word_t        mem [DEPTH];
  logic [RD_LATENCY-1:0] vld_pipe;
  logic [IDX_W-1:0]  idx_pipe [RD_LATENCY];
  int                rd_count = 0;
  int                wr_count = 0;

  // Observed writes, popped by the compare process
  logic [ADDR_W-1:0] wr_addr_q [$];
  feat_word_t        wr_data_q [$];

  // ========================================
  // Read side with fixed latency
  // ========================================
  assign feat_rd_valid = vld_pipe[RD_LATENCY-1];
  assign feat_rd_data  = mem[idx_pipe[RD_LATENCY-1]];

  always @(posedge CLK or negedge RESETn) begin
    if (!RESETn) begin
      vld_pipe <= '0;
      for (int i = 0; i < RD_LATENCY; i++) begin
        idx_pipe[i] <= '0;
      end
    end else begin
      vld_pipe    <= {vld_pipe[RD_LATENCY-2:0], feat_rd_en};
      idx_pipe[0] <= feat_rd_addr[IDX_W-1:0];
      for (int i = 1; i < RD_LATENCY; i++) begin
        idx_pipe[i] <= idx_pipe[i-1];
      end
    end
  end

  // ========================================
  // Traffic monitor
  // ========================================
  always @(posedge CLK) begin
    if (RESETn && feat_rd_en) begin
      rd_count = rd_count + 1;
    end
    if (RESETn && feat_wr_en) begin
      wr_addr_q.push_back(feat_wr_addr);
      wr_data_q.push_back(feat_wr_data);
      wr_count = wr_count + 1;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_layer_exec.sv
`timescale 1ns/100ps
`default_nettype none

module tb_layer_exec;
  import layer_exec_pkg::*;

  localparam int ADDR_W     = 16;
  localparam int CLK_PERIOD = 20;
  localparam int RD_LATENCY = 3;
  // Reads over all AP layers add up to 32 + 45 + 12 + 9 + 24 + 16
  localparam int TOTAL_READS     = 138;
  localparam int SETUP_CYCLES    = 120;
  localparam int WATCHDOG_CYCLES = 2 * (TOTAL_READS * (1 + RD_LATENCY) + SETUP_CYCLES);

  logic              CLK = 1'b0;
  logic              RESETn;
  logic              start;
  wire               done;
  layer_type_t       layer_type;
  chan_cnt_t         cin;
  dim_t              img_w;
  dim_t              img_h;
  quant_mult_t       quant_M;
  quant_shift_t      quant_s;
  quant_zp_t         quant_zp;
  wire               feat_rd_en;
  wire [ADDR_W-1:0]  feat_rd_addr;
  wire feat_word_t   feat_rd_data;
  wire               feat_rd_valid;
  wire               feat_wr_en;
  wire [ADDR_W-1:0]  feat_wr_addr;
  wire feat_word_t   feat_wr_data;

  integer            seed = 32'h84c4;
  logic [ADDR_W-1:0] exp_addr_q [$];
  feat_word_t        exp_data_q [$];
  logic [ADDR_W-1:0] exp_rd_q [$];
  logic [ADDR_W-1:0] got_addr;
  feat_word_t        got_data;
  logic [ADDR_W-1:0] want_addr;
  feat_word_t        want_data;
  logic [ADDR_W-1:0] want_rd_addr;

  layer_exec #(.ADDR_W(ADDR_W)) i_layer_exec (
    .CLK (CLK), .RESETn (RESETn), .start (start), .done (done),
    .layer_type (layer_type), .cin (cin), .img_w (img_w), .img_h (img_h),
    .quant_M (quant_M), .quant_s (quant_s), .quant_zp (quant_zp),
    .feat_rd_en (feat_rd_en), .feat_rd_addr (feat_rd_addr),
    .feat_rd_data (feat_rd_data), .feat_rd_valid (feat_rd_valid),
    .feat_wr_en (feat_wr_en), .feat_wr_addr (feat_wr_addr), .feat_wr_data (feat_wr_data)
  );

  tb_feature_mem #(.ADDR_W(ADDR_W), .RD_LATENCY(RD_LATENCY)) i_feature_mem (
    .CLK (CLK), .RESETn (RESETn),
    .feat_rd_en (feat_rd_en), .feat_rd_addr (feat_rd_addr),
    .feat_rd_data (feat_rd_data), .feat_rd_valid (feat_rd_valid),
    .feat_wr_en (feat_wr_en), .feat_wr_addr (feat_wr_addr), .feat_wr_data (feat_wr_data)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // ========================================
  // Reporting
  // ========================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Expected output word of block b from the buffer contents
  function automatic feat_word_t ref_word(input int b, input int blocks, input int pixels,
                                          input quant_mult_t m, input quant_shift_t s,
                                          input quant_zp_t zp);
    feat_word_t wd;
    feat_word_t res;
    longint     sum;
    longint     v;
    for (int l = 0; l < LANES; l++) begin
      sum = 0;
      for (int p = 0; p < pixels; p++) begin
        wd  = i_feature_mem.mem[8'(p * blocks + b)];
        sum = sum + longint'($signed(wd[l*DATA_W +: DATA_W]));
      end
      v = sum * longint'(m);
      // Round half up before the shift
      if (s != 0) begin
        v = v + (longint'(1) <<< (s - 1));
      end
      v = (v >>> s) + longint'(zp);
      if (v > 127) begin
        v = 127;
      end else if (v < -128) begin
        v = -128;
      end
      res[l*DATA_W +: DATA_W] = 8'(v);
    end
    return res;
  endfunction

  // ========================================
  // Stimulus helpers
  // ========================================
  task automatic fill_random();
    for (int a = 0; a < 256; a++) begin
      i_feature_mem.mem[a] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
  endtask

  // Block 0 near +127, block 1 near -128, the rest random
  task automatic fill_saturating(input int blocks);
    feat_word_t wd;
    for (int a = 0; a < 256; a++) begin
      for (int l = 0; l < LANES; l++) begin
        case (a % blocks)
          0:       wd[l*DATA_W +: DATA_W] = 8'(8'h60 + ((a * 7 + l) % 32));
          1:       wd[l*DATA_W +: DATA_W] = 8'(8'h80 + ((a * 5 + l) % 32));
          default: wd[l*DATA_W +: DATA_W] = 8'($random(seed));
        endcase
      end
      i_feature_mem.mem[a] = wd;
    end
  endtask

  task automatic run_bypass(input layer_type_t t);
    int rd0;
    int wr0;
    rd0 = i_feature_mem.rd_count;
    wr0 = i_feature_mem.wr_count;
    @(posedge CLK);
    #2;
    layer_type = t;
    start      = 1'b1;
    @(negedge CLK);
    check("done", 128'(done), 128'(0));
    @(posedge CLK);
    #2;
    start = 1'b0;
    @(negedge CLK);
    check("done", 128'(done), 128'(1));
    @(negedge CLK);
    check("done", 128'(done), 128'(0));
    check("read count", 128'(i_feature_mem.rd_count - rd0), 128'(0));
    check("write count", 128'(i_feature_mem.wr_count - wr0), 128'(0));
  endtask

  task automatic run_ap(input int c, input int w, input int h, input quant_mult_t m,
                        input quant_shift_t s, input quant_zp_t zp);
    int   blocks;
    int   wr0;
    logic prev_wr;
    blocks = (c + 15) / 16;
    for (int b = 0; b < blocks; b++) begin
      exp_addr_q.push_back(ADDR_W'(b));
      exp_data_q.push_back(ref_word(b, blocks, w * h, m, s, zp));
      // Reads walk every pixel of one block before the next block
      for (int p = 0; p < w * h; p++) begin
        exp_rd_q.push_back(ADDR_W'(p * blocks + b));
      end
    end
    wr0 = i_feature_mem.wr_count;
    @(posedge CLK);
    #2;
    layer_type = LAYER_AP;
    cin        = 11'(c);
    img_w      = 8'(w);
    img_h      = 8'(h);
    quant_M    = m;
    quant_s    = s;
    quant_zp   = zp;
    start      = 1'b1;
    @(negedge CLK);
    check("done", 128'(done), 128'(0));
    @(posedge CLK);
    #2;
    start   = 1'b0;
    prev_wr = 1'b0;
    @(negedge CLK);
    // Watchdog bounds this wait
    while (done !== 1'b1) begin
      prev_wr = feat_wr_en;
      @(negedge CLK);
    end
    check("feat_wr_en before done", 128'(prev_wr), 128'(1));
    check("write count", 128'(i_feature_mem.wr_count - wr0), 128'(blocks));
    check("pending reads", 128'(exp_rd_q.size()), 128'(0));
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    RESETn     = 1'b0;
    start      = 1'b0;
    layer_type = LAYER_CONV;
    cin        = '0;
    img_w      = '0;
    img_h      = '0;
    quant_M    = '0;
    quant_s    = '0;
    quant_zp   = '0;
    repeat (5) @(posedge CLK);
    #2;
    RESETn = 1'b1;
    @(negedge CLK);
    check("done", 128'(done), 128'(0));
    check("feat_rd_en", 128'(feat_rd_en), 128'(0));
    check("feat_wr_en", 128'(feat_wr_en), 128'(0));

    run_bypass(LAYER_CONV);
    run_bypass(LAYER_DW);
    run_bypass(LAYER_PW);
    run_bypass(LAYER_FC);

    // M carries the pool divide as 2**16 / area
    fill_random();
    run_ap(32, 4, 4, 16'sd4096, 6'd16, 8'sd0);
    run_ap(40, 3, 5, 16'sd4369, 6'd16, 8'sd0);

    fill_saturating(3);
    run_ap(48, 2, 2, 16'sh7fff, 6'd4, 8'sd5);

    fill_random();
    run_ap(16, 3, 3, 16'sd7282, 6'd16, -8'sd37);

    // Second layer starts right after done
    run_ap(64, 2, 3, 16'sd10923, 6'd16, 8'sd3);
    run_ap(24, 4, 2, -16'sd3000, 6'd12, -8'sd10);

    repeat (4) @(negedge CLK);
    check("done", 128'(done), 128'(0));
    if (exp_data_q.size() != 0) begin
      fail_run($sformatf("%0d expected writes never arrived", exp_data_q.size()));
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // Read address checker
  initial begin
    forever begin
      @(negedge CLK);
      if (feat_rd_en === 1'b1) begin
        if (exp_rd_q.size() == 0) begin
          fail_run($sformatf("Unexpected read of address %h at %0t ns",
                             feat_rd_addr, $time));
        end else begin
          want_rd_addr = exp_rd_q.pop_front();
          check("feat_rd_addr", 128'(feat_rd_addr), 128'(want_rd_addr));
        end
      end
    end
  end

  // Write checker
  initial begin
    forever begin
      @(negedge CLK);
      while (i_feature_mem.wr_data_q.size() != 0) begin
        got_addr = i_feature_mem.wr_addr_q.pop_front();
        got_data = i_feature_mem.wr_data_q.pop_front();
        if (exp_data_q.size() == 0) begin
          fail_run($sformatf("Unexpected write to address %h at %0t ns", got_addr, $time));
        end else begin
          want_addr = exp_addr_q.pop_front();
          want_data = exp_data_q.pop_front();
          check("feat_wr_addr", 128'(got_addr), 128'(want_addr));
          check("feat_wr_data", got_data, want_data);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("Run timed out before all layers finished");
  end

endmodule

`default_nettype wire
